// ==== list.f ====
source/ddc_pkg.sv
source/ddc_settings.sv
source/stream_fifo.sv
source/nco_mixer.sv
source/decim_accum.sv
source/ddc_chain.sv
verif/tb_ddc_chain.sv

// ==== Makefile ====
# Verilator build and run for the DDC chain testbench

TOP := tb_ddc_chain

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal -j 0 -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/tb_ddc_chain.sv ====
// Testbench for the DDC chain with reference model and scoreboard
// Bypass, IQ swap, NCO mixing, decimation, saturation and back-pressure
`timescale 1ns/10ps

module tb_ddc_chain import ddc_pkg::*; ();

  localparam int N_BYPASS = 24;
  localparam int N_SWAP   = 24;
  localparam int N_MIX    = 48;
  localparam int N_DECIM  = 48;
  localparam int N_SAT    = 64;
  localparam int N_BP     = 96;
  localparam int TOTAL    = N_BYPASS + N_SWAP + N_MIX + N_DECIM + N_SAT + N_BP;
  localparam int TIMEOUT_CYCLES = TOTAL * 20 + 3000;
  localparam int DRAIN_LIMIT    = 300;

  logic                 clk = 1'b0;
  logic                 i_rst;
  logic                 i_set_stb;
  logic [SR_ADDR_W-1:0] i_set_addr;
  logic [SR_DATA_W-1:0] i_set_data;
  iq_t                  i_tdata;
  logic                 i_tlast;
  logic                 i_tvalid;
  logic                 o_tready_in;
  iq_t                  o_tdata;
  logic                 o_tlast;
  logic                 o_sat;
  logic                 o_tvalid;
  logic                 i_tready_out = 1'b1;

  logic [31:0] rng_stim = 32'hd82a0b47;
  logic [31:0] rng_bp   = 32'hd82a0b47 ^ 32'h9e3779b9;
  logic        bp_en    = 1'b0;
  out_samp_t   exp_q[$];
  int          sat_seen = 0;

  // Shadow of the DUT configuration and model state
  logic [31:0] sh_inc, sh_phase;
  logic [7:0]  sh_n;
  logic [3:0]  sh_scale;
  logic        sh_swap, sh_bypass;
  longint      grp_i, grp_q;
  logic        grp_last;
  int          grp_cnt;

  ddc_chain dut0 (
    .i_ce_clk(clk), .i_rst(i_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready_in(o_tready_in),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_sat(o_sat), .o_tvalid(o_tvalid),
    .i_tready_out(i_tready_out));

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic signed [15:0] saturate_16(input longint v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return v[15:0];
  endfunction

  function automatic logic out_of_range(input longint v);
    return (v > 32767) || (v < -32768);
  endfunction

  // Swap, then complex multiply by cos/sin at the sample's phase
  function automatic iq_t model_sample(input iq_t s, input logic swap, input logic bypass,
                                       input logic [31:0] ph);
    iq_t        x;
    logic [5:0] idx;
    longint     sn, cs, mi, mq;
    x.i = swap ? s.q : s.i;
    x.q = swap ? s.i : s.q;
    if (bypass) return x;
    idx = ph[31:26];
    sn  = longint'(sine_lut(idx));
    cs  = longint'(sine_lut(idx + 6'd16));
    mi  = (longint'(x.i) * cs + longint'(x.q) * sn) >>> 15;
    mq  = (longint'(x.q) * cs - longint'(x.i) * sn) >>> 15;
    x.i = saturate_16(mi);
    x.q = saturate_16(mq);
    return x;
  endfunction

  function automatic iq_t rand_iq(input logic [31:0] r);
    iq_t x;
    x.i = r[15:0];
    x.q = r[31:16];
    return x;
  endfunction

  task automatic reset_group();
    grp_i    = 0;
    grp_q    = 0;
    grp_last = 1'b0;
    grp_cnt  = 0;
  endtask

  // Integrate and dump one model sample, queue the result on a full group
  task automatic add_to_model(input iq_t s, input logic last);
    iq_t       m;
    out_samp_t e;
    longint    si, sq;
    int        n_eff;
    m        = model_sample(s, sh_swap, sh_bypass, sh_phase);
    sh_phase = sh_phase + sh_inc;
    grp_i    = grp_i + longint'(m.i);
    grp_q    = grp_q + longint'(m.q);
    grp_last = grp_last | last;
    grp_cnt  = grp_cnt + 1;
    n_eff    = (sh_n == 8'd0) ? 1 : int'(sh_n);
    if (grp_cnt == n_eff) begin
      si      = grp_i >>> sh_scale;
      sq      = grp_q >>> sh_scale;
      e.iq.i  = saturate_16(si);
      e.iq.q  = saturate_16(sq);
      e.last  = grp_last;
      e.sat   = out_of_range(si) || out_of_range(sq);
      exp_q.push_back(e);
      reset_group();
    end
  endtask

  //////////////////////////////////////////////////
  // Checks and stimulus
  //////////////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s mismatch, got %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge clk);
    i_set_stb  = 1'b0;
    case (addr)
      SR_FREQ_ADDR: begin
        sh_inc   = data;
        sh_phase = '0;
      end
      SR_SCALE_IQ_ADDR: sh_scale = data[3:0];
      SR_DECIM_ADDR: begin
        sh_n = data[7:0];
        reset_group();
      end
      SR_MUX_ADDR: begin
        sh_swap   = data[MUX_SWAP_BIT];
        sh_bypass = data[MUX_BYPASS_BIT];
      end
      default: ;
    endcase
    repeat (2) @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      i_tvalid = 1'b0;
    end
  endtask

  // Hold the beat until the handshake edge
  task automatic send_sample(input iq_t s, input logic last);
    add_to_model(s, last);
    @(negedge clk);
    i_tdata  = s;
    i_tlast  = last;
    i_tvalid = 1'b1;
    while (!o_tready_in) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic send_random(input logic gaps);
    logic [31:0] r_data;
    logic [31:0] r_ctl;
    rng_stim = xorshift32(rng_stim);
    r_data   = rng_stim;
    rng_stim = xorshift32(rng_stim);
    r_ctl    = rng_stim;
    if (gaps && r_ctl[1:0] == 2'b00) idle_cycles(int'(r_ctl[3:2]) + 1);
    send_sample(rand_iq(r_data), r_ctl[7:5] == 3'b000);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    idle_cycles(1);
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    repeat (4) @(negedge clk);
  endtask

  // Output side drives ready and scores each beat before its handshake edge
  always @(negedge clk) begin
    out_samp_t exp;
    rng_bp       = xorshift32(rng_bp);
    i_tready_out = bp_en ? (rng_bp[2:0] < 3'd2) : 1'b1;
    if (!i_rst && o_tvalid === 1'b1 && i_tready_out) begin
      if (exp_q.size() == 0) begin
        report_failure("Output beat arrived with no expected value pending");
      end else begin
        exp = exp_q.pop_front();
        check_value(o_tdata, exp.iq, "output data");
        check_value(32'(o_tlast), 32'(exp.last), "output last");
        check_value(32'(o_sat), 32'(exp.sat), "output sat");
        if (exp.sat) sat_seen++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_failure($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    iq_t s;
    $timeformat(-9, 2, " ns", 10);
    i_rst = 1'b1;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata = '0;
    i_tlast = 1'b0;
    i_tvalid = 1'b0;
    sh_inc = '0;
    sh_phase = '0;
    sh_n = '0;
    sh_scale = '0;
    sh_swap = 1'b0;
    sh_bypass = 1'b0;
    reset_group();
    repeat (4) @(negedge clk);
    i_rst = 1'b0;

    // Bypass passthrough
    write_setting(SR_MUX_ADDR, 32'h2);
    write_setting(SR_DECIM_ADDR, 32'd1);
    write_setting(SR_SCALE_IQ_ADDR, 32'd0);
    repeat (N_BYPASS) send_random(1'b0);
    wait_drained();

    // IQ swap
    write_setting(SR_MUX_ADDR, 32'h3);
    repeat (N_SWAP) send_random(1'b0);
    wait_drained();

    // NCO mixing from a restarted phase
    write_setting(SR_FREQ_ADDR, 32'h0a3d70a4);
    write_setting(SR_MUX_ADDR, 32'h0);
    repeat (N_MIX) send_random(1'b0);
    wait_drained();

    // Decimation by 4 with shift of 2
    write_setting(SR_DECIM_ADDR, 32'd4);
    write_setting(SR_SCALE_IQ_ADDR, 32'd2);
    repeat (N_DECIM) send_random(1'b0);
    wait_drained();

    // Saturation, full-scale groups alternate with small ones
    write_setting(SR_MUX_ADDR, 32'h2);
    write_setting(SR_DECIM_ADDR, 32'd8);
    write_setting(SR_SCALE_IQ_ADDR, 32'd0);
    for (int g = 0; g < N_SAT / 8; g++) begin
      for (int k = 0; k < 8; k++) begin
        rng_stim = xorshift32(rng_stim);
        if (g % 2 == 0) begin
          s.i = 16'sh7fff;
          s.q = 16'sh8000;
        end else begin
          s.i = {{6{rng_stim[9]}}, rng_stim[9:0]};
          s.q = {{6{rng_stim[25]}}, rng_stim[25:16]};
        end
        send_sample(s, k == 7);
      end
    end
    wait_drained();
    check_value(32'(sat_seen), 32'(N_SAT / 16), "saturated output count");

    // Back-pressure with input gaps, swap and mixing, decimation by 3
    write_setting(SR_FREQ_ADDR, 32'h01234567);
    write_setting(SR_MUX_ADDR, 32'h1);
    write_setting(SR_DECIM_ADDR, 32'd3);
    write_setting(SR_SCALE_IQ_ADDR, 32'd1);
    bp_en = 1'b1;
    repeat (N_BP) send_random(1'b1);
    wait_drained();
    bp_en = 1'b0;

    if (exp_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      report_failure($sformatf("Output stream incomplete, %0d beats never arrived",
                               exp_q.size()));
    end
  end

endmodule

// ==== source/ddc_chain.sv ====
// DDC chain top, settings decoder, input FIFO, mixer, decimator, output FIFO
`timescale 1ns/10ps

module ddc_chain import ddc_pkg::*; (
  input  logic                 i_ce_clk,
  input  logic                 i_rst,
  // Setting bus
  input  logic                 i_set_stb,
  input  logic [SR_ADDR_W-1:0] i_set_addr,
  input  logic [SR_DATA_W-1:0] i_set_data,
  // Input stream
  input  iq_t                  i_tdata,
  input  logic                 i_tlast,
  input  logic                 i_tvalid,
  output logic                 o_tready_in,
  // Output stream
  output iq_t                  o_tdata,
  output logic                 o_tlast,
  output logic                 o_sat,
  output logic                 o_tvalid,
  input  logic                 i_tready_out
);

  ddc_cfg_t  cfg;
  logic      freq_restart;
  logic      decim_restart;

  in_samp_t  in_beat;
  in_samp_t  in_fifo_data;
  logic      in_fifo_valid;
  logic      in_fifo_ready;

  iq_t       mix_data;
  logic      mix_last;
  logic      mix_valid;
  logic      mix_ready;

  out_samp_t dec_data;
  logic      dec_valid;
  logic      dec_ready;

  out_samp_t out_fifo_data;

  assign in_beat.iq   = i_tdata;
  assign in_beat.last = i_tlast;

  assign o_tdata = out_fifo_data.iq;
  assign o_tlast = out_fifo_data.last;
  assign o_sat   = out_fifo_data.sat;

  ddc_settings settings0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_cfg(cfg), .o_freq_restart(freq_restart), .o_decim_restart(decim_restart));

  stream_fifo #(.payload_t(in_samp_t)) in_fifo0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_data(in_beat), .i_valid(i_tvalid), .o_ready(o_tready_in),
    .o_data(in_fifo_data), .o_valid(in_fifo_valid), .i_ready(in_fifo_ready));

  nco_mixer mixer0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_cfg(cfg), .i_freq_restart(freq_restart),
    .i_data(in_fifo_data.iq), .i_last(in_fifo_data.last),
    .i_valid(in_fifo_valid), .o_ready(in_fifo_ready),
    .o_data(mix_data), .o_last(mix_last), .o_valid(mix_valid), .i_ready(mix_ready));

  decim_accum decim0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_cfg(cfg), .i_decim_restart(decim_restart),
    .i_data(mix_data), .i_last(mix_last), .i_valid(mix_valid), .o_ready(mix_ready),
    .o_data(dec_data), .o_valid(dec_valid), .i_ready(dec_ready));

  stream_fifo #(.payload_t(out_samp_t)) out_fifo0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_data(dec_data), .i_valid(dec_valid), .o_ready(dec_ready),
    .o_data(out_fifo_data), .o_valid(o_tvalid), .i_ready(i_tready_out));

endmodule

// ==== source/decim_accum.sv ====
// Integrate-and-dump decimator over N samples
// Arithmetic shift scaling, 16-bit saturation and last OR over each group
`timescale 1ns/10ps

module decim_accum import ddc_pkg::*; (
  input  logic      i_ce_clk,
  input  logic      i_rst,
  input  ddc_cfg_t  i_cfg,
  input  logic      i_decim_restart,
  input  iq_t       i_data,
  input  logic      i_last,
  input  logic      i_valid,
  output logic      o_ready,
  output out_samp_t o_data,
  output logic      o_valid,
  input  logic      i_ready
);

  logic [DECIM_W-1:0]      n_eff;
  logic [DECIM_W-1:0]      count;
  logic signed [ACC_W-1:0] sum_i;
  logic signed [ACC_W-1:0] sum_q;
  logic                    last_or;

  logic                    accept;
  logic                    group_done;
  logic signed [ACC_W-1:0] next_i;
  logic signed [ACC_W-1:0] next_q;
  logic signed [ACC_W-1:0] scaled_i;
  logic signed [ACC_W-1:0] scaled_q;

  // N of zero behaves as one
  assign n_eff = (i_cfg.decim_n == '0) ? DECIM_W'(1) : i_cfg.decim_n;

  // No new input while a result waits downstream
  assign o_ready    = !o_valid || i_ready;
  assign accept     = i_valid && o_ready;
  assign group_done = (count == n_eff - 1'b1);

  assign next_i   = sum_i + i_data.i;
  assign next_q   = sum_q + i_data.q;
  assign scaled_i = next_i >>> i_cfg.scale;
  assign scaled_q = next_q >>> i_cfg.scale;

  //////////////////////////////////////////////////
  // Group accumulation
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst || i_decim_restart) begin
      count   <= '0;
      sum_i   <= '0;
      sum_q   <= '0;
      last_or <= 1'b0;
    end else if (accept) begin
      if (group_done) begin
        count   <= '0;
        sum_i   <= '0;
        sum_q   <= '0;
        last_or <= 1'b0;
      end else begin
        count   <= count + 1'b1;
        sum_i   <= next_i;
        sum_q   <= next_q;
        last_or <= last_or | i_last;
      end
    end
  end

  //////////////////////////////////////////////////
  // Dump register
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      if (o_valid && i_ready) begin
        o_valid <= 1'b0;
      end
      if (accept && group_done) begin
        o_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (accept && group_done) begin
      o_data.iq.i <= sat_samp(scaled_i);
      o_data.iq.q <= sat_samp(scaled_q);
      o_data.sat  <= clips(scaled_i) || clips(scaled_q);
      o_data.last <= last_or | i_last;
    end
  end

  // Count stays inside the group, a new N takes effect with the restart
  a_count_range: assert property (@(posedge i_ce_clk) disable iff (i_rst || i_decim_restart)
    count < n_eff);

endmodule

// ==== source/nco_mixer.sv ====
// NCO and complex mixer with optional IQ swap and bypass
// Two-stage pipeline, both stages frozen by one enable on output stall
`timescale 1ns/10ps

module nco_mixer import ddc_pkg::*; (
  input  logic     i_ce_clk,
  input  logic     i_rst,
  input  ddc_cfg_t i_cfg,
  input  logic     i_freq_restart,
  input  iq_t      i_data,
  input  logic     i_last,
  input  logic     i_valid,
  output logic     o_ready,
  output iq_t      o_data,
  output logic     o_last,
  output logic     o_valid,
  input  logic     i_ready
);

  // Products are Q15, drop the fraction
  localparam int MIX_SHIFT = SAMP_W - 1;

  logic                     pipe_en;
  logic [PHASE_W-1:0]       phase;
  logic [LUT_BITS-1:0]      lut_idx;
  iq_t                      in_swap;

  logic                     s1_valid;
  iq_t                      s1_samp;
  logic signed [SAMP_W-1:0] s1_sin;
  logic signed [SAMP_W-1:0] s1_cos;
  logic                     s1_last;

  logic signed [2*SAMP_W:0] mix_i;
  logic signed [2*SAMP_W:0] mix_q;

  assign pipe_en = !o_valid || i_ready;
  assign o_ready = pipe_en;
  assign lut_idx = phase[PHASE_W-1 -: LUT_BITS];

  always_comb begin
    in_swap = i_data;
    if (i_cfg.swap_iq) begin
      in_swap.i = i_data.q;
      in_swap.q = i_data.i;
    end
  end

  //////////////////////////////////////////////////
  // Phase accumulator
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst || i_freq_restart) begin
      phase <= '0;
    end else if (pipe_en && i_valid) begin
      // Sample takes the current phase, next one sees the advanced value
      phase <= phase + i_cfg.phase_inc;
    end
  end

  //////////////////////////////////////////////////
  // Stage one, sample and table lookup
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      s1_valid <= 1'b0;
    end else if (pipe_en) begin
      s1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (pipe_en && i_valid) begin
      s1_samp <= in_swap;
      s1_sin  <= sine_lut(lut_idx);
      s1_cos  <= sine_lut(lut_idx + LUT_BITS'(LUT_QUARTER));
      s1_last <= i_last;
    end
  end

  //////////////////////////////////////////////////
  // Stage two, complex multiply
  //////////////////////////////////////////////////
  assign mix_i = s1_samp.i * s1_cos + s1_samp.q * s1_sin;
  assign mix_q = s1_samp.q * s1_cos - s1_samp.i * s1_sin;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (pipe_en) begin
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (pipe_en && s1_valid) begin
      o_last <= s1_last;
      if (i_cfg.bypass_nco) begin
        o_data <= s1_samp;
      end else begin
        o_data.i <= sat_samp(mix_i >>> MIX_SHIFT);
        o_data.q <= sat_samp(mix_q >>> MIX_SHIFT);
      end
    end
  end

  // Output beat holds while the consumer stalls
  a_hold_stall: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data) && $stable(o_last)));

endmodule

// ==== source/stream_fifo.sv ====
// Small valid/ready FIFO, circular buffer with occupancy count
// Payload type is a parameter so one module buffers both stream formats
`timescale 1ns/10ps

module stream_fifo import ddc_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     i_ce_clk,
  input  logic     i_rst,
  input  payload_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  output payload_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  localparam int DEPTH = 2**FIFO_DEPTH_LOG2;

  payload_t                 mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       wr_en;
  logic                       rd_en;

  assign o_ready = (count != DEPTH[FIFO_DEPTH_LOG2:0]);
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign wr_en = i_valid && o_ready;
  assign rd_en = o_valid && i_ready;

  // Storage
  always_ff @(posedge i_ce_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy never passes the depth or wraps below zero
  a_no_write_full: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    count <= DEPTH[FIFO_DEPTH_LOG2:0]);

  // Empty buffer has both pointers on the same slot
  a_no_read_empty: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

// ==== source/ddc_settings.sv ====
// Setting bus decoder for the DDC chain
// Holds the configuration registers and the restart pulses
`timescale 1ns/10ps

module ddc_settings import ddc_pkg::*; (
  input  logic                 i_ce_clk,
  input  logic                 i_rst,
  input  logic                 i_set_stb,
  input  logic [SR_ADDR_W-1:0] i_set_addr,
  input  logic [SR_DATA_W-1:0] i_set_data,
  output ddc_cfg_t             o_cfg,
  output logic                 o_freq_restart,
  output logic                 o_decim_restart
);

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_cfg           <= '0;
      o_freq_restart  <= 1'b0;
      o_decim_restart <= 1'b0;
    end else begin
      // Pulses last a single cycle
      o_freq_restart  <= 1'b0;
      o_decim_restart <= 1'b0;
      if (i_set_stb) begin
        case (i_set_addr)
          SR_FREQ_ADDR: begin
            o_cfg.phase_inc <= i_set_data[PHASE_W-1:0];
            o_freq_restart  <= 1'b1;
          end
          SR_SCALE_IQ_ADDR: begin
            o_cfg.scale <= i_set_data[SHIFT_W-1:0];
          end
          SR_DECIM_ADDR: begin
            o_cfg.decim_n   <= i_set_data[DECIM_W-1:0];
            o_decim_restart <= 1'b1;
          end
          SR_MUX_ADDR: begin
            o_cfg.swap_iq    <= i_set_data[MUX_SWAP_BIT];
            o_cfg.bypass_nco <= i_set_data[MUX_BYPASS_BIT];
          end
          default: begin
            // Unknown address, nothing changes
          end
        endcase
      end
    end
  end

endmodule

// ==== source/ddc_pkg.sv ====
// Shared types, setting addresses and widths for the DDC chain
// Also quarter-wave sine table and 16-bit saturation helpers
package ddc_pkg;

  // Datapath widths
  localparam int SAMP_W          = 16;
  localparam int PHASE_W         = 32;
  localparam int LUT_BITS        = 6;
  localparam int ACC_W           = 32;
  localparam int DECIM_W         = 8;
  localparam int SHIFT_W         = 4;
  localparam int FIFO_DEPTH_LOG2 = 3;

  // Setting bus
  localparam int SR_ADDR_W = 8;
  localparam int SR_DATA_W = 32;

  // User register space, same addresses as the NoC block
  localparam logic [SR_ADDR_W-1:0] SR_FREQ_ADDR     = 8'd132;
  localparam logic [SR_ADDR_W-1:0] SR_SCALE_IQ_ADDR = 8'd133;
  localparam logic [SR_ADDR_W-1:0] SR_DECIM_ADDR    = 8'd134;
  localparam logic [SR_ADDR_W-1:0] SR_MUX_ADDR      = 8'd136;

  // Bit positions inside the mux register
  localparam int MUX_SWAP_BIT   = 0;
  localparam int MUX_BYPASS_BIT = 1;

  // Clip limits of one output component
  localparam int SAMP_MAX = 2**(SAMP_W-1) - 1;
  localparam int SAMP_MIN = -(2**(SAMP_W-1));

  // One quarter of a sine period in table steps
  localparam int LUT_QUARTER = 2**(LUT_BITS-2);

  typedef struct packed {
    logic signed [SAMP_W-1:0] i;
    logic signed [SAMP_W-1:0] q;
  } iq_t;

  typedef struct packed {
    iq_t  iq;
    logic last;
  } in_samp_t;

  typedef struct packed {
    iq_t  iq;
    logic last;
    logic sat;
  } out_samp_t;

  typedef struct packed {
    logic [PHASE_W-1:0] phase_inc;
    logic [DECIM_W-1:0] decim_n;
    logic [SHIFT_W-1:0] scale;
    logic               swap_iq;
    logic               bypass_nco;
  } ddc_cfg_t;

  // sin(k * 2pi / 64) * 32767 for k = 0 .. 16
  localparam logic signed [SAMP_W-1:0] SINE_TABLE [LUT_QUARTER+1] = '{
    16'sd0,     16'sd3212,  16'sd6393,  16'sd9512,  16'sd12539, 16'sd15446,
    16'sd18204, 16'sd20787, 16'sd23170, 16'sd25329, 16'sd27245, 16'sd28898,
    16'sd30273, 16'sd31356, 16'sd32137, 16'sd32609, 16'sd32767
  };

  // Full-period sine from the quarter table, mirrored and negated per quadrant
  function automatic logic signed [SAMP_W-1:0] sine_lut(input logic [LUT_BITS-1:0] idx);
    logic [LUT_BITS-2:0]      offs;
    logic signed [SAMP_W-1:0] mag;
    offs = idx[LUT_BITS-2] ? (LUT_BITS-1)'(LUT_QUARTER) - {1'b0, idx[LUT_BITS-3:0]}
                           : {1'b0, idx[LUT_BITS-3:0]};
    mag  = SINE_TABLE[offs];
    return idx[LUT_BITS-1] ? -mag : mag;
  endfunction

  function automatic logic signed [SAMP_W-1:0] sat_samp(input logic signed [ACC_W:0] x);
    if (x > SAMP_MAX) return SAMP_W'(SAMP_MAX);
    if (x < SAMP_MIN) return SAMP_W'(SAMP_MIN);
    return x[SAMP_W-1:0];
  endfunction

  function automatic logic clips(input logic signed [ACC_W:0] x);
    return (x > SAMP_MAX) || (x < SAMP_MIN);
  endfunction

endpackage
